//--- rtl/pdp_nan_pkg.sv
// shared widths, beat layout and control states for the pdp nan stage, used by scoped name
package pdp_nan_pkg;

  // beat geometry
  localparam int elem_w   = 16;
  localparam int elem_num = 4;

  // input_data code for fp16 input
  localparam logic [1:0] input_fp16 = 2'd2;

  // one fp16 element
  // sign 15, exponent 14:10, mantissa 9:0
  typedef logic [elem_w-1:0] fp16_t;

  // flagged element count within one beat, 0..4
  typedef logic [2:0] elem_cnt_t;

  // info field, 12 bits, msb first
  // split_end sits four below cube_end, the rest rides along untouched
  typedef struct packed {
    logic       cube_end;
    logic [2:0] info_rest_hi;
    logic       split_end;
    logic [6:0] info_rest_lo;
  } pdp_info_t;

  // flat 76-bit beat, element 0 in the low bits
  typedef struct packed {
    pdp_info_t                  info;
    fp16_t [elem_num-1:0]       elem;
  } pdp_beat_t;

  // per-beat summary kept next to the output register
  typedef struct packed {
    logic      cube_end;
    elem_cnt_t nan_num;
    elem_cnt_t inf_num;
  } beat_stat_t;

  // layer gating
  typedef enum logic {st_wait_op_en, st_run} ctrl_state_e;

endpackage

//--- rtl/pdp_nan_layer_ctrl.sv
// layer gating for the nan stage: holds input off until op_en rises, makes in_ready and load
`timescale 1ns/1ns
module pdp_nan_layer_ctrl (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   op_en,
  input  logic                   in_valid,
  input  pdp_nan_pkg::pdp_info_t in_info,
  input  logic                   out_pvld,
  input  logic                   out_prdy,
  output logic                   in_ready,
  output logic                   load
);

  pdp_nan_pkg::ctrl_state_e state;
  logic                     op_en_d1;
  logic                     op_en_rise;
  logic                     layer_end;

  //////////////////////////////////////////////////
  // input handshake
  //////////////////////////////////////////////////

  // room in the output register, either empty or draining now
  assign in_ready = (state == pdp_nan_pkg::st_run) & (~out_pvld | out_prdy);
  assign load     = in_valid & in_ready;

  //////////////////////////////////////////////////
  // waiting for op_en
  //////////////////////////////////////////////////

  assign op_en_rise = op_en & ~op_en_d1;
  // last beat of the layer
  assign layer_end  = load & in_info.cube_end & in_info.split_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state    <= pdp_nan_pkg::st_wait_op_en;
      op_en_d1 <= 1'b0;
    end else begin
      op_en_d1 <= op_en;
      // layer end has priority over a new op_en edge
      if (layer_end) begin
        state <= pdp_nan_pkg::st_wait_op_en;
      end else if (op_en_rise) begin
        state <= pdp_nan_pkg::st_run;
      end
    end
  end

endmodule

//--- rtl/pdp_nan_flush.sv
// nan/inf classification, optional flush to zero and the single output register of the stage
`timescale 1ns/1ns
module pdp_nan_flush (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic                    load,
  input  pdp_nan_pkg::pdp_beat_t  in_pd,
  input  logic [1:0]              input_data,
  input  logic                    nan_to_zero,
  input  logic                    out_prdy,
  output pdp_nan_pkg::pdp_beat_t  out_pd,
  output logic                    out_pvld,
  output pdp_nan_pkg::beat_stat_t stat
);

  logic                             fp16_en;
  logic [pdp_nan_pkg::elem_num-1:0] is_nan;
  logic [pdp_nan_pkg::elem_num-1:0] is_inf;
  pdp_nan_pkg::elem_cnt_t           nan_num;
  pdp_nan_pkg::elem_cnt_t           inf_num;
  pdp_nan_pkg::pdp_beat_t           flushed;

  // classification only means something for fp16
  assign fp16_en = (input_data == pdp_nan_pkg::input_fp16);

  //////////////////////////////////////////////////
  // per element classify and flush
  //////////////////////////////////////////////////

  always_comb begin
    flushed = in_pd;
    nan_num = '0;
    inf_num = '0;
    for (int i = 0; i < pdp_nan_pkg::elem_num; i++) begin
      // exponent all ones, mantissa decides nan vs inf
      is_nan[i] = fp16_en & (&in_pd.elem[i][14:10]) & (|in_pd.elem[i][9:0]);
      is_inf[i] = fp16_en & (&in_pd.elem[i][14:10]) & ~(|in_pd.elem[i][9:0]);
      if (is_nan[i] & nan_to_zero) begin
        flushed.elem[i] = '0;
      end
      // infinities are never flushed, only counted
      nan_num = nan_num + pdp_nan_pkg::elem_cnt_t'(is_nan[i]);
      inf_num = inf_num + pdp_nan_pkg::elem_cnt_t'(is_inf[i]);
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // payload and beat summary, captured on accept
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      out_pd        <= flushed;
      stat.cube_end <= in_pd.info.cube_end;
      stat.nan_num  <= nan_num;
      stat.inf_num  <= inf_num;
    end
  end

  // valid holds until taken, reloads back to back
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_pvld <= 1'b0;
    end else if (load) begin
      out_pvld <= 1'b1;
    end else if (out_prdy) begin
      out_pvld <= 1'b0;
    end
  end

endmodule

//--- rtl/pdp_nan_count.sv
// per-cube nan/inf counters with ping-pong result slots, read out on each write-side done
`timescale 1ns/1ns
module pdp_nan_count #(
  parameter int count_w = 32
) (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  pdp_nan_pkg::beat_stat_t stat,
  input  logic                    out_pvld,
  input  logic                    out_prdy,
  input  logic                    done,
  output logic [count_w-1:0]      nan_input_num,
  output logic [count_w-1:0]      inf_input_num
);

  logic                    accept;
  logic                    cube_done;
  logic [count_w-1:0]      nan_in_count;
  logic [count_w-1:0]      inf_in_count;
  logic [1:0][count_w-1:0] nan_slot;
  logic [1:0][count_w-1:0] inf_slot;
  logic                    store_sel;
  logic                    read_sel;

  // output beat leaves the stage
  assign accept    = out_pvld & out_prdy;
  assign cube_done = accept & stat.cube_end;

  //////////////////////////////////////////////////
  // running counts
  //////////////////////////////////////////////////

  // cube end beat clears, its own elements are not added
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_in_count <= '0;
      inf_in_count <= '0;
    end else if (accept) begin
      if (stat.cube_end) begin
        nan_in_count <= '0;
        inf_in_count <= '0;
      end else begin
        nan_in_count <= nan_in_count + count_w'(stat.nan_num);
        inf_in_count <= inf_in_count + count_w'(stat.inf_num);
      end
    end
  end

  //////////////////////////////////////////////////
  // ping-pong store
  //////////////////////////////////////////////////

  // pre-clear totals go to the slot picked by store_sel
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      store_sel <= 1'b0;
      nan_slot  <= '0;
      inf_slot  <= '0;
    end else if (cube_done) begin
      store_sel           <= ~store_sel;
      nan_slot[store_sel] <= nan_in_count;
      inf_slot[store_sel] <= inf_in_count;
    end
  end

  //////////////////////////////////////////////////
  // register side report
  //////////////////////////////////////////////////

  // one slot per done, in the order the cubes finished
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      read_sel      <= 1'b0;
      nan_input_num <= '0;
      inf_input_num <= '0;
    end else if (done) begin
      read_sel      <= ~read_sel;
      nan_input_num <= nan_slot[read_sel];
      inf_input_num <= inf_slot[read_sel];
    end
  end

endmodule

//--- rtl/pdp_nan.sv
// top of the pdp nan pre-processing stage: layer gating, flush register and nan/inf counts
`timescale 1ns/1ns
module pdp_nan #(
  parameter int count_w = 32
) (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  // input beats from rdma
  input  pdp_nan_pkg::pdp_beat_t in_pd,
  input  logic                   in_valid,
  output logic                   in_ready,
  // pre-processed beats
  output pdp_nan_pkg::pdp_beat_t out_pd,
  output logic                   out_pvld,
  input  logic                   out_prdy,
  // register levels
  input  logic                   op_en,
  input  logic [1:0]             input_data,
  input  logic                   nan_to_zero,
  // write side done pulse
  input  logic                   done,
  // per cube results
  output logic [count_w-1:0]     nan_input_num,
  output logic [count_w-1:0]     inf_input_num
);

  logic                    load;
  pdp_nan_pkg::beat_stat_t stat;

  // gating and input handshake
  pdp_nan_layer_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .in_valid        (in_valid),
    .in_info         (in_pd.info),
    .out_pvld        (out_pvld),
    .out_prdy        (out_prdy),
    .in_ready        (in_ready),
    .load            (load)
  );

  // classify, flush, register
  pdp_nan_flush u_flush (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .load            (load),
    .in_pd           (in_pd),
    .input_data      (input_data),
    .nan_to_zero     (nan_to_zero),
    .out_prdy        (out_prdy),
    .out_pd          (out_pd),
    .out_pvld        (out_pvld),
    .stat            (stat)
  );

  // counts on the output side
  pdp_nan_count #(
    .count_w (count_w)
  ) u_count (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .stat            (stat),
    .out_pvld        (out_pvld),
    .out_prdy        (out_prdy),
    .done            (done),
    .nan_input_num   (nan_input_num),
    .inf_input_num   (inf_input_num)
  );

endmodule

//--- tests/pdp_nan_assert.sv
// concurrent checks on the nan stage handshake and running counters, bound into the top level
`timescale 1ns/1ns
module pdp_nan_assert #(
  parameter int count_w = 32
) (
  input logic                    nvdla_core_clk,
  input logic                    nvdla_core_rstn,
  input pdp_nan_pkg::pdp_beat_t  out_pd,
  input logic                    out_pvld,
  input logic                    out_prdy,
  input logic                    in_ready,
  input pdp_nan_pkg::beat_stat_t stat,
  input logic [count_w-1:0]      nan_count,
  input logic [count_w-1:0]      inf_count
);

  // held beat must not move under back-pressure
  hold_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_pvld && !out_prdy |=> $stable(out_pd))
    else $error("out_pd changed while the output was stalled");

  // no new beat while the register is full and stuck
  stall_no_ready: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_pvld && !out_prdy |-> !in_ready)
    else $error("in_ready high while the output register was stalled");

  // running counts stay below the wrap point
  nan_no_wrap: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_pvld && out_prdy && !stat.cube_end |->
      nan_count <= ({count_w{1'b1}} - count_w'(stat.nan_num)))
    else $error("nan counter wrapped");
  inf_no_wrap: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_pvld && out_prdy && !stat.cube_end |->
      inf_count <= ({count_w{1'b1}} - count_w'(stat.inf_num)))
    else $error("inf counter wrapped");

endmodule

bind pdp_nan pdp_nan_assert #(.count_w(count_w)) u_assert (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .out_pd          (out_pd),
  .out_pvld        (out_pvld),
  .out_prdy        (out_prdy),
  .in_ready        (in_ready),
  .stat            (stat),
  .nan_count       (u_count.nan_in_count),
  .inf_count       (u_count.inf_in_count)
);

//--- tests/pdp_nan_tb.sv
// simulation top that drives random beats into the pdp nan stage and checks beats, gating and counts
`timescale 1ns/1ns
module pdp_nan_tb;

  // expected output beat with its flagged element counts
  typedef struct packed {
    pdp_nan_pkg::pdp_beat_t beat;
    pdp_nan_pkg::elem_cnt_t nan_cnt;
    pdp_nan_pkg::elem_cnt_t inf_cnt;
  } exp_t;

  logic                   nvdla_core_clk;
  logic                   nvdla_core_rstn;
  pdp_nan_pkg::pdp_beat_t in_pd;
  pdp_nan_pkg::pdp_beat_t out_pd;
  logic                   in_valid, in_ready, out_pvld, out_prdy;
  logic                   op_en, nan_to_zero, done;
  logic [1:0]             input_data;
  logic [31:0]            nan_input_num, inf_input_num;

  // scoreboard and model state
  exp_t        exp_q[$];
  logic [31:0] lfsr;
  logic [31:0] run_nan, run_inf;
  logic [31:0] slot_nan[2];
  logic [31:0] slot_inf[2];
  logic        store_sel, read_sel, rand_prdy;
  int          errors, checks;

  pdp_nan #(.count_w(32)) pdp_nan_inst (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // half the elements are forced to nan or inf codes
  function automatic pdp_nan_pkg::fp16_t gen_elem();
    logic [1:0]          kind;
    pdp_nan_pkg::fp16_t  v;
    kind = 2'(take_bits(2));
    v = 16'(take_bits(16));
    if (kind == 2'd0) begin
      v[14:10] = 5'h1f;
      v[0] = v[0] | ~(|v[9:1]);
    end else if (kind == 2'd1) begin
      v[14:0] = {5'h1f, 10'h000};
    end
    return v;
  endfunction

  function automatic pdp_nan_pkg::pdp_beat_t gen_beat(input logic cube_end, input logic split_end);
    pdp_nan_pkg::pdp_beat_t b;
    b.info = 12'(take_bits(12));
    b.info.cube_end = cube_end;
    b.info.split_end = split_end;
    for (int i = 0; i < pdp_nan_pkg::elem_num; i++) begin
      b.elem[i] = gen_elem();
    end
    return b;
  endfunction

  // expected beat and counts from the fp16 nan and inf rules
  function automatic exp_t model_beat(input pdp_nan_pkg::pdp_beat_t b, input logic [1:0] mode,
                                      input logic ftz);
    exp_t e;
    e.beat = b;
    e.nan_cnt = '0;
    e.inf_cnt = '0;
    for (int i = 0; i < 4; i++) begin
      if (mode == 2'd2 && b.elem[i][14:10] == 5'h1f) begin
        if (b.elem[i][9:0] != 10'h0) begin
          e.nan_cnt = e.nan_cnt + 3'd1;
          if (ftz) e.beat.elem[i] = 16'h0000;
        end else begin
          e.inf_cnt = e.inf_cnt + 3'd1;
        end
      end
    end
    return e;
  endfunction

  // advance one clock and sample the handshake at the edge
  task automatic tick(output logic acc, output logic rdy);
    @(posedge nvdla_core_clk);
    acc = in_valid & in_ready;
    rdy = in_ready;
    #1;
    out_prdy = rand_prdy ? (take_bits(2) != 32'd0) : 1'b1;
  endtask

  task automatic send_beat(input pdp_nan_pkg::pdp_beat_t b);
    logic acc, rdy;
    int   t;
    in_valid = 1'b0;
    if (take_bits(2) == 32'd0) tick(acc, rdy);
    in_pd = b;
    in_valid = 1'b1;
    acc = 1'b0;
    t = 0;
    while (!acc && t < 100) begin
      tick(acc, rdy);
      t++;
    end
    in_valid = 1'b0;
    assert (acc) else begin
      errors++;
      $display("timed out waiting for the stage to accept a beat");
    end
    if (acc) exp_q.push_back(model_beat(b, input_data, nan_to_zero));
  endtask

  task automatic send_cube(input int n, input logic layer_end);
    for (int i = 0; i < n; i++) begin
      send_beat(gen_beat(i == n - 1, layer_end && (i == n - 1)));
    end
  endtask

  task automatic drain();
    logic acc, rdy;
    int   t;
    t = 0;
    while (exp_q.size() != 0 && t < 200) begin
      tick(acc, rdy);
      t++;
    end
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("timed out waiting for output beats to drain");
    end
  endtask

  task automatic wait_ready();
    logic acc, rdy;
    int   t;
    rdy = 1'b0;
    t = 0;
    while (!rdy && t < 20) begin
      tick(acc, rdy);
      t++;
    end
    assert (rdy) else begin
      errors++;
      $display("timed out waiting for in_ready after op_en rose");
    end
  endtask

  // input must stay closed while waiting for op_en
  task automatic check_gated(input int n);
    logic acc, rdy;
    in_valid = 1'b0;
    repeat (n) begin
      tick(acc, rdy);
      checks++;
      assert (!rdy) else begin
        errors++;
        $display("error in_ready expected %h got %h", 1'b0, rdy);
      end
    end
  endtask

  // done pulse reads the next ping-pong slot
  task automatic check_done();
    logic        acc, rdy;
    logic [31:0] exp_nan, exp_inf;
    exp_nan = slot_nan[read_sel];
    exp_inf = slot_inf[read_sel];
    read_sel = ~read_sel;
    done = 1'b1;
    tick(acc, rdy);
    done = 1'b0;
    checks += 2;
    assert (nan_input_num == exp_nan) else begin
      errors++;
      $display("error nan_input_num expected %h got %h", exp_nan, nan_input_num);
    end
    assert (inf_input_num == exp_inf) else begin
      errors++;
      $display("error inf_input_num expected %h got %h", exp_inf, inf_input_num);
    end
  endtask

  ////////////////////////////////////////////////////
  // compare output beats and update the count model
  ////////////////////////////////////////////////////

  always @(posedge nvdla_core_clk) begin : compare_out
    exp_t e;
    if (nvdla_core_rstn && out_pvld && out_prdy) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("output beat arrived with none expected");
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (out_pd == e.beat) else begin
          errors++;
          $display("error out_pd expected %h got %h", e.beat, out_pd);
        end
        // cube end beat stores and clears without adding its own flags
        if (e.beat.info.cube_end) begin
          slot_nan[store_sel] = run_nan;
          slot_inf[store_sel] = run_inf;
          store_sel = ~store_sel;
          run_nan = '0;
          run_inf = '0;
        end else begin
          run_nan = run_nan + 32'(e.nan_cnt);
          run_inf = run_inf + 32'(e.inf_cnt);
        end
      end
    end
  end

  ////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////

  initial begin
    logic acc, rdy;
    nvdla_core_rstn = 1'b0;
    in_pd = '0;
    in_valid = 1'b0;
    out_prdy = 1'b1;
    op_en = 1'b0;
    input_data = 2'd2;
    nan_to_zero = 1'b1;
    done = 1'b0;
    lfsr = 32'h0e2f8fab;
    run_nan = '0;
    run_inf = '0;
    slot_nan = '{32'h0, 32'h0};
    slot_inf = '{32'h0, 32'h0};
    store_sel = 1'b0;
    read_sel = 1'b0;
    rand_prdy = 1'b0;
    errors = 0;
    checks = 0;
    repeat (3) @(posedge nvdla_core_clk);
    #1 nvdla_core_rstn = 1'b1;
    // closed until op_en rises
    check_gated(5);
    op_en = 1'b1;
    wait_ready();
    // fp16 with flush and output always ready
    send_cube(6, 1'b0);
    drain();
    check_done();
    // flush off under random back-pressure
    nan_to_zero = 1'b0;
    rand_prdy = 1'b1;
    send_cube(8, 1'b0);
    drain();
    check_done();
    // non fp16 passes through with zero counts
    input_data = 2'd1;
    nan_to_zero = 1'b1;
    send_cube(5, 1'b0);
    drain();
    check_done();
    // two cubes before any done
    input_data = 2'd2;
    send_cube(7, 1'b0);
    send_cube(4, 1'b0);
    drain();
    check_done();
    check_done();
    // layer end closes the input again
    send_cube(5, 1'b1);
    drain();
    check_done();
    check_gated(5);
    op_en = 1'b0;
    tick(acc, rdy);
    op_en = 1'b1;
    wait_ready();
    send_cube(6, 1'b0);
    drain();
    check_done();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/pdp_nan_pkg.sv
rtl/pdp_nan_layer_ctrl.sv
rtl/pdp_nan_flush.sv
rtl/pdp_nan_count.sv
rtl/pdp_nan.sv
tests/pdp_nan_assert.sv
tests/pdp_nan_tb.sv

//--- Bender.yml
package:
  name: pdp_nan

sources:
  - files:
      - rtl/pdp_nan_pkg.sv
      - rtl/pdp_nan_layer_ctrl.sv
      - rtl/pdp_nan_flush.sv
      - rtl/pdp_nan_count.sv
      - rtl/pdp_nan.sv
  - target: test
    files:
      - tests/pdp_nan_assert.sv
      - tests/pdp_nan_tb.sv
